//--- hw/stream_pkg.sv
////////////////////////////////////////////////////////////
// byte stream definitions
// beat formats for the command and response streams
////////////////////////////////////////////////////////////
`default_nettype none

package stream_pkg;

  localparam int unsigned data_w = 8;

  // sop marks the first byte of a packet and eop the last one
  typedef struct packed {
    logic              sop;
    logic              eop;
    logic [data_w-1:0] data;
  } cmd_beat_t;

  // response bytes carry captured tdo bits, first bit in the lsb
  typedef struct packed {
    logic              sop;
    logic              eop;
    logic [data_w-1:0] data;
  } resp_beat_t;

endpackage

`default_nettype wire

//--- hw/jtag_pkg.sv
////////////////////////////////////////////////////////////
// jtag command definitions
// opcodes, config subcommands, shift counter widths and the
// capture window and shift chunk types
////////////////////////////////////////////////////////////
`default_nettype none

package jtag_pkg;

  // the opcode sits in bits 7:5 of a command header byte
  typedef enum logic [2:0] {
    cmd_config        = 3'd0,
    cmd_write_window  = 3'd2,
    cmd_short_tms_tdi = 3'd4,
    cmd_long_tdi      = 3'd5
  } opcode_e;

  // config subcommand in header bits 1:0
  typedef enum logic [1:0] {
    clear_windows = 2'd1
  } subcmd_e;

  localparam int unsigned bit_count_w     = 13;
  localparam int unsigned chunk_max_short = 3;
  localparam int unsigned chunk_max_long  = 7;
  localparam int unsigned duration_w      = 15;
  localparam int unsigned window_depth    = 2;

  // an all zero window marks an empty slot
  typedef struct packed {
    logic                  capture;
    logic                  eop_gen;
    logic [duration_w-1:0] duration;
  } window_t;

  // one burst of bits for the shift engine, last is the final bit index
  typedef struct packed {
    logic [chunk_max_long:0] tms;
    logic [chunk_max_long:0] tdi;
    logic [3:0]              last;
  } chunk_t;

endpackage

`default_nettype wire

//--- hw/cmd_sequencer.sv
////////////////////////////////////////////////////////////
// command sequencer
// parses command bytes, issues shift chunks to the shift
// engine and window writes to the capture window FIFO
////////////////////////////////////////////////////////////
`default_nettype none

module cmd_sequencer (
  input  logic                  clk,
  input  logic                  reset,
  input  stream_pkg::cmd_beat_t cmd_beat,
  input  logic                  cmd_valid,
  output logic                  cmd_ready,
  output jtag_pkg::chunk_t      chunk,
  output logic                  chunk_start,
  input  logic                  chunk_done,
  output jtag_pkg::window_t     window_in,
  output logic                  window_write,
  output logic                  clear_windows,
  output logic                  sop_seen,
  input  logic                  capture_en,
  input  logic                  resp_busy
);
  import jtag_pkg::*;

  typedef enum logic [2:0] {
    st_header,
    st_length,
    st_win_mid,
    st_win_top,
    st_get_byte,
    st_shift
  } state_e;

  state_e                 state;
  state_e                 state_nxt;
  opcode_e                opcode;
  opcode_e                op_in;
  logic [bit_count_w-1:0] bits_left;
  logic [duration_w-3:0]  dur_low;
  logic [3:0]             chunk_max;
  logic [3:0]             chunk_last;
  logic                   last_chunk;
  logic                   ready_q;
  logic                   accept;

  assign op_in = opcode_e'(cmd_beat.data[7:5]);

  // while a response byte is held, no chunk may start that would capture more
  // bits, so the data byte is simply not taken
  assign cmd_ready = ready_q & ~((state == st_get_byte) & capture_en & resp_busy);
  assign accept    = cmd_valid & cmd_ready;

  // long commands move 8 tdi bits per byte, short ones 4 tms/tdi pairs
  assign chunk_max  = (opcode == cmd_long_tdi) ? 4'(chunk_max_long) : 4'(chunk_max_short);
  assign chunk_last = (bits_left > chunk_max) ? chunk_max : bits_left[3:0];

  always_comb begin
    if (opcode == cmd_long_tdi) begin
      chunk = {8'h00, cmd_beat.data, chunk_last};
    end else begin
      chunk = {4'h0, cmd_beat.data[7:4], 4'h0, cmd_beat.data[3:0], chunk_last};
    end
  end

  // the top duration bits come straight from the third window byte
  assign window_in = {cmd_beat.data[7], cmd_beat.data[6], cmd_beat.data[1:0], dur_low};

  always_comb begin
    state_nxt     = state;
    chunk_start   = 1'b0;
    window_write  = 1'b0;
    clear_windows = 1'b0;
    sop_seen      = 1'b0;
    case (state)
      st_header: begin
        if (accept) begin
          sop_seen = cmd_beat.sop;
          case (op_in)
            cmd_config: begin
              // other subcommands are taken and dropped
              clear_windows = (subcmd_e'(cmd_beat.data[1:0]) == jtag_pkg::clear_windows);
            end
            cmd_write_window:  state_nxt = st_win_mid;
            cmd_short_tms_tdi: state_nxt = st_get_byte;
            cmd_long_tdi:      state_nxt = st_length;
            default:           state_nxt = st_header;
          endcase
        end
      end
      st_length: begin
        if (accept) begin
          state_nxt = st_get_byte;
        end
      end
      st_win_mid: begin
        if (accept) begin
          state_nxt = st_win_top;
        end
      end
      st_win_top: begin
        if (accept) begin
          window_write = 1'b1;
          state_nxt    = st_header;
        end
      end
      st_get_byte: begin
        if (accept) begin
          chunk_start = 1'b1;
          state_nxt   = st_shift;
        end
      end
      st_shift: begin
        // one data byte per chunk, the next byte is fetched only after the last bit
        if (chunk_done) begin
          state_nxt = last_chunk ? st_header : st_get_byte;
        end
      end
      default: state_nxt = st_header;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state      <= st_header;
      ready_q    <= 1'b0;
      opcode     <= cmd_config;
      bits_left  <= '0;
      last_chunk <= 1'b0;
    end else begin
      state   <= state_nxt;
      ready_q <= (state_nxt != st_shift);
      if (accept) begin
        case (state)
          st_header: begin
            opcode    <= op_in;
            bits_left <= bit_count_w'(cmd_beat.data[4:0]);
          end
          st_length: bits_left[bit_count_w-1:5] <= cmd_beat.data;
          st_get_byte: begin
            // bits_left holds the count minus one, as the header does
            last_chunk <= (bits_left <= chunk_max);
            if (bits_left > chunk_max) begin
              bits_left <= bits_left - chunk_max - 1'b1;
            end
          end
          default: ;
        endcase
      end
    end
  end

  // low duration bits are collected over the first two window bytes
  always_ff @(posedge clk) begin
    if (accept && state == st_header) begin
      dur_low[4:0] <= cmd_beat.data[4:0];
    end else if (accept && state == st_win_mid) begin
      dur_low[duration_w-3:5] <= cmd_beat.data;
    end
  end

endmodule

`default_nettype wire

//--- hw/shift_engine.sv
////////////////////////////////////////////////////////////
// shift engine
// serializes one chunk of tms/tdi bits, one bit per clock
// with tck_en high
////////////////////////////////////////////////////////////
`default_nettype none

module shift_engine (
  input  logic             clk,
  input  logic             reset,
  input  jtag_pkg::chunk_t chunk,
  input  logic             chunk_start,
  output logic             chunk_done,
  output logic             tck_en,
  output logic             tms,
  output logic             tdi
);
  import jtag_pkg::*;

  logic [chunk_max_long:0] tms_sr;
  logic [chunk_max_long:0] tdi_sr;
  logic [3:0]              bit_cnt;

  // tck_en rises the clock after chunk_start and stays up for last+1 clocks
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      tck_en  <= 1'b0;
      bit_cnt <= '0;
    end else if (chunk_start) begin
      tck_en  <= 1'b1;
      bit_cnt <= chunk.last;
    end else if (tck_en) begin
      if (bit_cnt == '0) begin
        tck_en <= 1'b0;
      end else begin
        bit_cnt <= bit_cnt - 1'b1;
      end
    end
  end

  // bits leave lsb first
  always_ff @(posedge clk) begin
    if (chunk_start) begin
      tms_sr <= chunk.tms;
      tdi_sr <= chunk.tdi;
    end else if (tck_en) begin
      tms_sr <= tms_sr >> 1;
      tdi_sr <= tdi_sr >> 1;
    end
  end

  assign tms        = tms_sr[0];
  assign tdi        = tdi_sr[0];
  assign chunk_done = tck_en & (bit_cnt == '0);

endmodule

`default_nettype wire

//--- hw/window_loader.sv
////////////////////////////////////////////////////////////
// capture window loader
// steers window writes into the slots, tracks how many are
// in use and refuses writes while all are taken
////////////////////////////////////////////////////////////
`default_nettype none

module window_loader (
  input  logic                                clk,
  input  logic                                reset,
  input  jtag_pkg::window_t                   window_in,
  input  logic                                window_write,
  input  logic                                slot_clear,
  input  jtag_pkg::window_t                   slot_state [jtag_pkg::window_depth],
  input  logic [jtag_pkg::window_depth-1:0]   slot_dec,
  output logic [jtag_pkg::window_depth-1:0]   slot_write,
  output logic                                full
);
  import jtag_pkg::*;

  logic [$clog2(window_depth)-1:0]   wr_ptr;
  logic [$clog2(window_depth+1)-1:0] count;
  logic                              accept;
  logic                              retire;

  assign full = (count == window_depth);

  // an all zero window would read back as an empty slot, so it is not stored
  assign accept = window_write & ~full & (window_in != '0);

  always_comb begin
    retire = 1'b0;
    for (int i = 0; i < window_depth; i++) begin
      slot_write[i] = accept & (wr_ptr == i);
      // a slot frees itself on the tck seen at duration zero
      if (slot_dec[i] && slot_state[i] != '0 && slot_state[i].duration == '0) begin
        retire = 1'b1;
      end
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      count  <= '0;
    end else if (slot_clear) begin
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (accept) begin
        wr_ptr <= (wr_ptr == window_depth - 1) ? '0 : wr_ptr + 1'b1;
      end
      count <= count + accept - retire;
    end
  end

endmodule

`default_nettype wire

//--- hw/window_slot.sv
////////////////////////////////////////////////////////////
// capture window slot
// holds one window and counts its duration down per tck
////////////////////////////////////////////////////////////
`default_nettype none

module window_slot (
  input  logic              clk,
  input  logic              reset,
  input  logic              write,
  input  jtag_pkg::window_t window_in,
  input  logic              dec,
  input  logic              clear,
  output jtag_pkg::window_t slot_state
);

  // the slot is empty when all of its bits are zero
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      slot_state <= '0;
    end else if (clear) begin
      slot_state <= '0;
    end else if (write) begin
      slot_state <= window_in;
    end else if (dec && slot_state != '0) begin
      // duration zero still covers one more tck, so a window spans duration+1
      if (slot_state.duration == '0) begin
        slot_state <= '0;
      end else begin
        slot_state.duration <= slot_state.duration - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/window_reader.sv
////////////////////////////////////////////////////////////
// capture window reader
// follows the oldest slot, routes tck to it and reports
// capture enable and the end of each window
////////////////////////////////////////////////////////////
`default_nettype none

module window_reader (
  input  logic                              clk,
  input  logic                              reset,
  input  jtag_pkg::window_t                 slot_state [jtag_pkg::window_depth],
  input  logic                              tck_en,
  input  logic                              slot_clear,
  output logic [jtag_pkg::window_depth-1:0] slot_dec,
  output logic                              capture_en,
  output logic                              window_end,
  output logic                              eop_mark
);
  import jtag_pkg::*;

  logic [$clog2(window_depth)-1:0] rd_ptr;
  window_t                         active;
  logic                            occupied;

  assign active   = slot_state[rd_ptr];
  assign occupied = (active != '0);

  // an empty slot has its capture flag low, so capture stops between windows
  assign capture_en = active.capture;
  assign window_end = tck_en & occupied & (active.duration == '0);
  assign eop_mark   = window_end & active.eop_gen;

  always_comb begin
    for (int i = 0; i < window_depth; i++) begin
      slot_dec[i] = tck_en & (rd_ptr == i);
    end
  end

  // the next slot takes over on the clock after the final tck
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rd_ptr <= '0;
    end else if (slot_clear) begin
      rd_ptr <= '0;
    end else if (window_end) begin
      rd_ptr <= (rd_ptr == window_depth - 1) ? '0 : rd_ptr + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- hw/tdo_response.sv
////////////////////////////////////////////////////////////
// tdo response builder
// packs captured tdo bits into bytes and offers them on the
// response stream
////////////////////////////////////////////////////////////
`default_nettype none

module tdo_response (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   tck_en,
  input  logic                   tdo,
  input  logic                   capture_en,
  input  logic                   window_end,
  input  logic                   eop_mark,
  input  logic                   sop_seen,
  output stream_pkg::resp_beat_t resp_beat,
  output logic                   resp_valid,
  input  logic                   resp_ready,
  output logic                   resp_busy
);
  import stream_pkg::*;

  typedef enum logic {
    rs_idle,
    rs_offer
  } resp_state_e;

  resp_state_e               state;
  logic [data_w-1:0]         acc;
  logic [data_w-1:0]         acc_nxt;
  logic [$clog2(data_w)-1:0] bit_cnt;
  logic                      capture;
  logic                      flush;
  logic                      sop_pending;

  assign capture = tck_en & capture_en;

  // the first captured bit lands in the lsb
  always_comb begin
    acc_nxt = acc;
    if (capture) begin
      acc_nxt[bit_cnt] = tdo;
    end
  end

  // send on a full byte, or on a window end with a partial byte pending
  assign flush = (capture & (bit_cnt == data_w - 1)) |
                 (window_end & (capture | (bit_cnt != '0)));

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state       <= rs_idle;
      acc         <= '0;
      bit_cnt     <= '0;
      sop_pending <= 1'b0;
    end else begin
      case (state)
        rs_idle:  if (flush) state <= rs_offer;
        rs_offer: if (resp_ready && !flush) state <= rs_idle;
        default:  state <= rs_idle;
      endcase
      // unfilled bits of a partial byte stay zero
      if (flush) begin
        acc     <= '0;
        bit_cnt <= '0;
      end else begin
        acc <= acc_nxt;
        if (capture) begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end
      if (sop_seen) begin
        sop_pending <= 1'b1;
      end else if (flush) begin
        sop_pending <= 1'b0;
      end
    end
  end

  // the beat is loaded on the completing tck and offered the clock after
  always_ff @(posedge clk) begin
    if (flush) begin
      resp_beat.sop  <= sop_pending;
      resp_beat.eop  <= eop_mark;
      resp_beat.data <= acc_nxt;
    end
  end

  assign resp_valid = (state == rs_offer);
  assign resp_busy  = resp_valid & ~resp_ready;

endmodule

`default_nettype wire

//--- hw/jtag_stream_ctrl.sv
////////////////////////////////////////////////////////////
// jtag stream controller top level
// turns command bytes into tms/tdi bit strobes and returns
// captured tdo bits as response bytes
////////////////////////////////////////////////////////////
`default_nettype none

module jtag_stream_ctrl (
  input  logic                   clk,
  input  logic                   reset,
  input  stream_pkg::cmd_beat_t  cmd_beat,
  input  logic                   cmd_valid,
  output logic                   cmd_ready,
  output stream_pkg::resp_beat_t resp_beat,
  output logic                   resp_valid,
  input  logic                   resp_ready,
  output logic                   tck_en,
  output logic                   tms,
  output logic                   tdi,
  input  logic                   tdo
);
  import jtag_pkg::*;

  chunk_t                  chunk;
  logic                    chunk_start;
  logic                    chunk_done;
  window_t                 window_in;
  logic                    window_write;
  logic                    slot_clear;
  logic                    sop_seen;
  logic [window_depth-1:0] slot_write;
  logic [window_depth-1:0] slot_dec;
  window_t                 slot_state [window_depth];
  logic                    capture_en;
  logic                    window_end;
  logic                    eop_mark;
  logic                    resp_busy;

  cmd_sequencer u_sequencer (
    .clk           (clk),
    .reset         (reset),
    .cmd_beat      (cmd_beat),
    .cmd_valid     (cmd_valid),
    .cmd_ready     (cmd_ready),
    .chunk         (chunk),
    .chunk_start   (chunk_start),
    .chunk_done    (chunk_done),
    .window_in     (window_in),
    .window_write  (window_write),
    .clear_windows (slot_clear),
    .sop_seen      (sop_seen),
    .capture_en    (capture_en),
    .resp_busy     (resp_busy)
  );

  shift_engine u_shift (
    .clk         (clk),
    .reset       (reset),
    .chunk       (chunk),
    .chunk_start (chunk_start),
    .chunk_done  (chunk_done),
    .tck_en      (tck_en),
    .tms         (tms),
    .tdi         (tdi)
  );

  // the full flag only gates writes inside the loader
  window_loader u_loader (
    .clk          (clk),
    .reset        (reset),
    .window_in    (window_in),
    .window_write (window_write),
    .slot_clear   (slot_clear),
    .slot_state   (slot_state),
    .slot_dec     (slot_dec),
    .slot_write   (slot_write),
    .full         ()
  );

  for (genvar i = 0; i < window_depth; i++) begin : g_slot
    window_slot u_slot (
      .clk        (clk),
      .reset      (reset),
      .write      (slot_write[i]),
      .window_in  (window_in),
      .dec        (slot_dec[i]),
      .clear      (slot_clear),
      .slot_state (slot_state[i])
    );
  end

  window_reader u_reader (
    .clk        (clk),
    .reset      (reset),
    .slot_state (slot_state),
    .tck_en     (tck_en),
    .slot_clear (slot_clear),
    .slot_dec   (slot_dec),
    .capture_en (capture_en),
    .window_end (window_end),
    .eop_mark   (eop_mark)
  );

  tdo_response u_response (
    .clk        (clk),
    .reset      (reset),
    .tck_en     (tck_en),
    .tdo        (tdo),
    .capture_en (capture_en),
    .window_end (window_end),
    .eop_mark   (eop_mark),
    .sop_seen   (sop_seen),
    .resp_beat  (resp_beat),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready),
    .resp_busy  (resp_busy)
  );

endmodule

`default_nettype wire

//--- tb/jtag_stream_ctrl_chk.sv
////////////////////////////////////////////////////////////
// protocol checker for the jtag stream controller
// bound into the top level, watches the response handshake
// and the outputs that reset holds low
////////////////////////////////////////////////////////////
`default_nettype none

module jtag_stream_ctrl_chk (
  input logic                   clk,
  input logic                   reset,
  input logic                   cmd_ready,
  input stream_pkg::resp_beat_t resp_beat,
  input logic                   resp_valid,
  input logic                   resp_ready,
  input logic                   tck_en
);

  // number of failed assertions, read by the testbench at the end of the run
  int fail_count = 0;

  // a response that is not taken stays offered with the same contents
  resp_hold_a: assert property (@(posedge clk) disable iff (reset)
    (resp_valid && !resp_ready) |=> (resp_valid && $stable(resp_beat)))
    else begin
      fail_count = fail_count + 1;
      $error("response valid dropped or beat changed before it was accepted");
    end

  // nothing is offered or shifted while reset is high
  reset_cmd_a: assert property (@(posedge clk) reset |-> !cmd_ready)
    else begin
      fail_count = fail_count + 1;
      $error("cmd_ready high during reset");
    end

  reset_resp_a: assert property (@(posedge clk) reset |-> !resp_valid)
    else begin
      fail_count = fail_count + 1;
      $error("resp_valid high during reset");
    end

  reset_tck_a: assert property (@(posedge clk) reset |-> !tck_en)
    else begin
      fail_count = fail_count + 1;
      $error("tck_en high during reset");
    end

endmodule

bind jtag_stream_ctrl jtag_stream_ctrl_chk chk (
  .clk        (clk),
  .reset      (reset),
  .cmd_ready  (cmd_ready),
  .resp_beat  (resp_beat),
  .resp_valid (resp_valid),
  .resp_ready (resp_ready),
  .tck_en     (tck_en)
);

`default_nettype wire

//--- tb/tb_jtag_stream_ctrl.sv
////////////////////////////////////////////////////////////
// testbench for the jtag stream controller
// sends random commands, loops tdi back to tdo and checks
// the bit strobes and response bytes against a model
////////////////////////////////////////////////////////////
`default_nettype none

module tb_jtag_stream_ctrl;
  import stream_pkg::*;
  import jtag_pkg::*;

  typedef struct packed {
    logic tms;
    logic tdi;
  } bit_pair_t;

  localparam int num_steps = 30;
  // a step sends at most a window, a clear and a long shift with 6 data bytes
  localparam int max_step_bytes  = 12;
  localparam int watchdog_cycles = num_steps * max_step_bytes * 40 + 2000;

  logic       clk = 1'b0;
  logic       reset;
  cmd_beat_t  cmd_beat;
  logic       cmd_valid;
  logic       cmd_ready;
  resp_beat_t resp_beat;
  logic       resp_valid;
  logic       resp_ready;
  logic       tck_en;
  logic       tms;
  logic       tdi;
  logic       tdo;

  // bytes still to send, bits still to shift, responses still to arrive
  cmd_beat_t  cmd_q [$];
  bit_pair_t  bit_q [$];
  resp_beat_t resp_q [$];
  window_t    win_q [$];

  logic [31:0] stim_seed      = 32'ha432fd0c;
  logic [31:0] ready_seed     = 32'ha432fd0c;
  int          ready_low_left = 0;
  logic        loop_tdi       = 1'b0;
  logic        sop_pending    = 1'b0;
  logic [7:0]  acc            = '0;
  int          acc_cnt        = 0;
  int          mismatches     = 0;
  int          other_errors   = 0;

  jtag_stream_ctrl dut (
    .clk        (clk),
    .reset      (reset),
    .cmd_beat   (cmd_beat),
    .cmd_valid  (cmd_valid),
    .cmd_ready  (cmd_ready),
    .resp_beat  (resp_beat),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready),
    .tck_en     (tck_en),
    .tms        (tms),
    .tdi        (tdi),
    .tdo        (tdo)
  );

  initial begin
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // the upper half of the state has the better random bits
  task automatic draw(output int unsigned v);
    stim_seed = lcg_step(stim_seed);
    v = stim_seed[31:16];
  endtask

  task automatic queue_byte(input logic sop, input logic eop, input logic [7:0] data);
    cmd_q.push_back({sop, eop, data});
  endtask

  // any header sent with sop marks the next response byte
  task automatic queue_header(input logic [7:0] data, input logic last);
    int unsigned r;
    draw(r);
    if (r[3]) begin
      sop_pending = 1'b1;
    end
    queue_byte(r[3], last, data);
  endtask

  // each data byte of a short command holds 4 tms bits over 4 tdi bits
  task automatic send_short();
    int unsigned r;
    logic [4:0]  len;
    logic [7:0]  data;
    draw(r);
    len = r[4:0];
    queue_header({cmd_short_tms_tdi, len}, 1'b0);
    for (int i = 0; i <= len; i += 4) begin
      draw(r);
      data = r[7:0];
      queue_byte(1'b0, (i + 4 > len), data);
      for (int j = 0; j < 4 && i + j <= len; j++) begin
        bit_q.push_back({data[4 + j], data[j]});
      end
    end
  endtask

  // long command shifts n+1 tdi bits with tms held low
  task automatic send_long(input int n);
    int unsigned r;
    logic [12:0] nv;
    logic [7:0]  data;
    nv = 13'(n);
    queue_header({cmd_long_tdi, nv[4:0]}, 1'b0);
    queue_byte(1'b0, 1'b0, nv[12:5]);
    for (int i = 0; i <= n; i += 8) begin
      draw(r);
      data = r[7:0];
      queue_byte(1'b0, (i + 8 > n), data);
      for (int j = 0; j < 8 && i + j <= n; j++) begin
        bit_q.push_back({1'b0, data[j]});
      end
    end
  endtask

  task automatic send_window(input int dur, input logic eop_gen);
    logic [14:0] d;
    window_t     w;
    d = 15'(dur);
    queue_header({cmd_write_window, d[4:0]}, 1'b0);
    queue_byte(1'b0, 1'b0, d[12:5]);
    queue_byte(1'b0, 1'b1, {1'b1, eop_gen, 4'h0, d[14:13]});
    w.capture  = 1'b1;
    w.eop_gen  = eop_gen;
    w.duration = d;
    // a write into a full window FIFO is dropped
    if (win_q.size() < window_depth) begin
      win_q.push_back(w);
    end
  endtask

  task automatic send_clear();
    queue_header({cmd_config, 3'b000, 2'b01}, 1'b1);
    win_q.delete();
  endtask

  // unknown opcodes and unknown config subcommands are both dropped
  task automatic send_ignored();
    int unsigned r;
    draw(r);
    if (r[0]) begin
      queue_header({2'b11, r[6], r[11:7]}, 1'b1);
    end else begin
      queue_header({cmd_config, 3'b000, 1'b1, r[5]}, 1'b1);
    end
  endtask

  task automatic wait_idle();
    while (cmd_q.size() != 0 || bit_q.size() != 0) begin
      @(negedge clk);
    end
    repeat (2) @(negedge clk);
  endtask

  // the model takes one tck here and a window covers duration+1 tcks
  task automatic model_capture(input logic tdo_bit);
    logic win_end;
    if (win_q.size() != 0) begin
      if (win_q[0].capture) begin
        acc[acc_cnt] = tdo_bit;
        acc_cnt++;
      end
      win_end = (win_q[0].duration == '0);
      if (acc_cnt == 8 || (win_end && acc_cnt != 0)) begin
        resp_q.push_back({sop_pending, win_end & win_q[0].eop_gen, acc});
        sop_pending = 1'b0;
        acc         = '0;
        acc_cnt     = 0;
      end
      if (win_end) begin
        win_q.delete(0);
      end else begin
        win_q[0].duration = win_q[0].duration - 1'b1;
      end
    end
  endtask

  // inputs change on the falling edge and ready drops now and then for a few cycles
  always @(negedge clk) begin
    ready_seed = lcg_step(ready_seed);
    if (ready_low_left != 0) begin
      resp_ready     = 1'b0;
      ready_low_left = ready_low_left - 1;
    end else if (ready_seed[31:29] == 3'd0) begin
      resp_ready     = 1'b0;
      ready_low_left = ready_seed[27:25];
    end else begin
      resp_ready = 1'b1;
    end
    cmd_valid = (cmd_q.size() != 0);
    cmd_beat  = (cmd_q.size() != 0) ? cmd_q[0] : '0;
    // the target returns the tdi of the previous tck
    tdo = loop_tdi;
  end

  always @(posedge clk) begin : monitor
    bit_pair_t  exp_bit;
    resp_beat_t exp_resp;
    if (!reset) begin
      if (cmd_valid && cmd_ready) begin
        cmd_q.delete(0);
      end
      if (tck_en) begin
        if (bit_q.size() == 0) begin
          other_errors++;
          $display("error at %0t: tck_en strobe with no bit left to shift", $time);
        end else begin
          exp_bit = bit_q.pop_front();
          assert (tms == exp_bit.tms) else begin
            mismatches++;
            $display("MISMATCH at %0t: tms expected %b actual %b", $time, exp_bit.tms, tms);
          end
          assert (tdi == exp_bit.tdi) else begin
            mismatches++;
            $display("MISMATCH at %0t: tdi expected %b actual %b", $time, exp_bit.tdi, tdi);
          end
          model_capture(loop_tdi);
          loop_tdi = exp_bit.tdi;
        end
      end
      if (resp_valid && resp_ready) begin
        if (resp_q.size() == 0) begin
          other_errors++;
          $display("error at %0t: response byte %h sent when none was due", $time, resp_beat);
        end else begin
          exp_resp = resp_q.pop_front();
          assert (resp_beat == exp_resp) else begin
            mismatches++;
            $display("MISMATCH at %0t: resp_beat expected %h actual %h",
                     $time, exp_resp, resp_beat);
          end
        end
      end
    end
  end

  initial begin : stimulus
    int unsigned r;
    int          n;
    reset     = 1'b1;
    cmd_valid = 1'b0;
    cmd_beat  = '0;
    resp_ready = 1'b0;
    tdo       = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    for (int step = 0; step < num_steps; step++) begin
      draw(r);
      n = r % 41;
      case (step % 5)
        0: send_short();
        1: send_long(n);
        2: begin
          // the window ends inside the shift that follows it
          draw(r);
          send_window(r % (n + 1), r[8]);
          send_long(n);
        end
        3: begin
          send_window(n, 1'b1);
          send_clear();
          send_long(n);
        end
        default: send_ignored();
      endcase
      wait_idle();
    end
    while (resp_q.size() != 0) begin
      @(negedge clk);
    end
    repeat (20) @(negedge clk);
    $display("errors: %0d mismatches, %0d other, %0d checker",
             mismatches, other_errors, dut.chk.fail_count);
    if (mismatches + other_errors + dut.chk.fail_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (watchdog_cycles) @(posedge clk);
    $display("error: run stopped after %0d cycles without finishing", watchdog_cycles);
    $display("errors: %0d mismatches, %0d other, %0d checker",
             mismatches, other_errors, dut.chk.fail_count);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
hw/stream_pkg.sv
hw/jtag_pkg.sv
hw/cmd_sequencer.sv
hw/shift_engine.sv
hw/window_loader.sv
hw/window_slot.sv
hw/window_reader.sv
hw/tdo_response.sv
hw/jtag_stream_ctrl.sv
tb/jtag_stream_ctrl_chk.sv
tb/tb_jtag_stream_ctrl.sv
